//--- Bender.yml
package:
  name: l1_refill

sources:
  - design/refill_cfg_pkg.sv
  - design/refill_bus_pkg.sv
  - design/refill_addr_track.sv
  - design/refill_fsm.sv
  - design/refill_fill_port.sv
  - design/l1_refill_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_l1_refill.sv

//--- build.f
+incdir+sim
design/refill_cfg_pkg.sv
design/refill_bus_pkg.sv
design/refill_addr_track.sv
design/refill_fsm.sv
design/refill_fill_port.sv
design/l1_refill_top.sv
sim/tb_l1_refill.sv

//--- design/l1_refill_top.sv
// Instruction cache refill top with address capture, FSM and fill port
`default_nettype none

module l1_refill_top #(
  parameter int PC_W = 39
) (
  input  logic                       l1_refill_clk,
  input  logic                       cpurst_b,
  input  refill_bus_pkg::miss_req_t  miss,
  input  logic                       inv_on,
  input  logic                       inv_busy,
  input  logic                       chgflw,
  input  refill_bus_pkg::bus_beat_t  beat,
  output refill_bus_pkg::bus_req_t   bus_out,
  output refill_bus_pkg::icache_wr_t icache_out,
  output refill_bus_pkg::ifdp_data_t ifdp_out,
  output logic                       ipctrl_busy,
  output logic                       ifctrl_idle,
  output logic                       ifctrl_refill_on,
  output logic                       ifctrl_reissue,
  output logic                       trans_cmplt,
  output logic                       icache_miss_pre
);

  import refill_cfg_pkg::*;
  import refill_bus_pkg::*;

  logic [PC_W-1:0] vpc;
  logic [PC_W-1:0] ppc;
  refill_attr_t    attr;
  refill_state_e   state;
  logic            inc;

  // ======================================================================
  // Stage 1, address and attribute capture
  // ======================================================================
  refill_addr_track #(
    .PC_W (PC_W)
  ) u_addr_track (
    .l1_refill_clk (l1_refill_clk),
    .cpurst_b      (cpurst_b),
    .miss          (miss),
    .inc           (inc),
    .vpc           (vpc),
    .ppc           (ppc),
    .attr          (attr)
  );

  // ======================================================================
  // Stage 2, refill sequencing
  // ======================================================================
  refill_fsm u_fsm (
    .l1_refill_clk (l1_refill_clk),
    .cpurst_b      (cpurst_b),
    .miss_valid    (miss.valid),
    .inv_on        (inv_on),
    .inv_busy      (inv_busy),
    .chgflw        (chgflw),
    .beat          (beat),
    .tsize         (attr.tsize),
    .state         (state),
    .inc           (inc),
    .busy          (ipctrl_busy),
    .refill_on     (ifctrl_refill_on),
    .bus_req       (bus_out.req),
    .bus_refill_on (bus_out.refill_on),
    .trans_cmplt   (trans_cmplt),
    .miss_pre      (icache_miss_pre)
  );

  // Byte PCs toward the bus, halfword aligned
  assign bus_out.vpc  = (PC_BITS+1)'({vpc, 1'b0});
  assign bus_out.ppc  = (PC_BITS+1)'({ppc, 1'b0});
  assign bus_out.attr = attr;

  assign ifctrl_idle = !ipctrl_busy;

  // ======================================================================
  // Stage 3, cache and fetch stage fill
  // ======================================================================
  refill_fill_port #(
    .PC_W (PC_W)
  ) u_fill_port (
    .state      (state),
    .tsize      (attr.tsize),
    .beat       (beat),
    .vpc        (vpc),
    .ppc        (ppc),
    .refill_on  (ifctrl_refill_on),
    .icache_out (icache_out),
    .ifdp_out   (ifdp_out),
    .reissue    (ifctrl_reissue)
  );

endmodule

`default_nettype wire

//--- design/refill_addr_track.sv
// Captured virtual and physical fetch PC and attributes, stepped one beat at a time
`default_nettype none

module refill_addr_track #(
  parameter int PC_W = 39
) (
  input  logic                         l1_refill_clk,
  input  logic                         cpurst_b,
  input  refill_bus_pkg::miss_req_t    miss,
  input  logic                         inc,
  output logic [PC_W-1:0]              vpc,
  output logic [PC_W-1:0]              ppc,
  output refill_bus_pkg::refill_attr_t attr
);

  import refill_cfg_pkg::*;

  // Beat offset field within the line
  localparam int BEAT_MSB = BEAT_LSB + $clog2(LINE_BEATS) - 1;

  // Next beat address, wraps inside the line
  function automatic logic [PC_W-1:0] next_beat(input logic [PC_W-1:0] pc);
    logic [PC_W-1:0] nxt;
    nxt = pc;
    nxt[BEAT_MSB:BEAT_LSB] = pc[BEAT_MSB:BEAT_LSB] + 1'b1;
    nxt[BEAT_LSB-1:0] = '0;
    return nxt;
  endfunction

  // ======================================================================
  // Line address
  // ======================================================================
  always_ff @(posedge l1_refill_clk)
  begin
    if (miss.valid)
    begin
      vpc <= miss.vpc[PC_W-1:0];
      ppc <= miss.ppc[PC_W-1:0];
    end
    else if (inc)
    begin
      vpc <= next_beat(vpc);
      ppc <= next_beat(ppc);
    end
  end

  // ======================================================================
  // Access attributes
  // ======================================================================
  // Held for the whole refill, tsize also steers the FSM
  always_ff @(posedge l1_refill_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      attr <= '0;
    end
    else if (miss.valid)
    begin
      attr <= miss.attr;
    end
  end

endmodule

`default_nettype wire

//--- design/refill_bus_pkg.sv
// Packed structs for miss request, bus request, bus beat, cache write and fetch data
`default_nettype none

package refill_bus_pkg;

  // Widths of the fixed PC and tag fields in the structs
  localparam int PC_BITS   = 39;
  localparam int PTAG_BITS = PC_BITS - refill_cfg_pkg::TAG_LSB;

  // Access attributes, tsize 1 is a full line
  typedef struct packed {
    logic tsize;
    logic cacheable;
    logic bufferable;
    logic supv_mode;
    logic machine_mode;
    logic secure;
  } refill_attr_t;

  // Miss from the fetch stage, PCs hold pc bits 39:1
  typedef struct packed {
    logic               valid;
    logic [PC_BITS-1:0] vpc;
    logic [PC_BITS-1:0] ppc;
    refill_attr_t       attr;
  } miss_req_t;

  // Request toward the bus interface, full byte PCs
  typedef struct packed {
    logic             req;
    logic             refill_on;
    logic [PC_BITS:0] vpc;
    logic [PC_BITS:0] ppc;
    refill_attr_t     attr;
  } bus_req_t;

  // One returned beat
  typedef struct packed {
    logic                                 grnt;
    logic                                 data_vld;
    logic                                 trans_err;
    logic [refill_cfg_pkg::BEAT_BITS-1:0] rdata;
  } bus_beat_t;

  // Instruction cache write port
  typedef struct packed {
    logic                                 wr;
    logic                                 first;
    logic                                 last;
    logic [PC_BITS-1:0]                   index;
    logic [PTAG_BITS-1:0]                 ptag;
    logic [refill_cfg_pkg::BEAT_BITS-1:0] inst_data;
  } icache_wr_t;

  // Bypass data to the fetch stage
  typedef struct packed {
    logic                                 refill_on;
    logic [refill_cfg_pkg::BEAT_BITS-1:0] inst_data;
    logic                                 tag_valid;
    logic [PTAG_BITS-1:0]                 ptag;
    logic                                 acc_err;
  } ifdp_data_t;

endpackage

`default_nettype wire

//--- design/refill_cfg_pkg.sv
// Refill state encoding, line geometry constants and state decode helper
`default_nettype none

package refill_cfg_pkg;

  // ======================================================================
  // Refill FSM states
  // ======================================================================
  // Bit 2 marks the four WFD states, bit 3 the drain states
  typedef enum logic [3:0] {
    IDLE     = 4'b0000,
    REQ      = 4'b0001,
    WFD1     = 4'b0100,
    WFD2     = 4'b0101,
    WFD3     = 4'b0110,
    WFD4     = 4'b0111,
    INV_WFD1 = 4'b1000,
    INV_WFD2 = 4'b1001,
    INV_WFD3 = 4'b1010,
    INV_WFD4 = 4'b1011
  } refill_state_e;

  // ======================================================================
  // Line geometry
  // ======================================================================
  localparam int LINE_BEATS = 4;
  localparam int BEAT_BITS  = 128;
  localparam int HWORD_BITS = 16;

  // PC bit positions, counted on pc bits 39:1
  localparam int TAG_LSB  = 11;
  localparam int BEAT_LSB = 3;

  // True while a valid line beat is expected
  function automatic logic is_wfd(input refill_state_e st);
    return st[2];
  endfunction

endpackage

`default_nettype wire

//--- design/refill_fill_port.sv
// Halfword reversal of beat data and per-beat cache write, tag and reissue decode
`default_nettype none

module refill_fill_port #(
  parameter int PC_W = 39
) (
  input  refill_cfg_pkg::refill_state_e state,
  input  logic                          tsize,
  input  refill_bus_pkg::bus_beat_t     beat,
  input  logic [PC_W-1:0]               vpc,
  input  logic [PC_W-1:0]               ppc,
  input  logic                          refill_on,
  output refill_bus_pkg::icache_wr_t    icache_out,
  output refill_bus_pkg::ifdp_data_t    ifdp_out,
  output logic                          reissue
);

  import refill_cfg_pkg::*;
  import refill_bus_pkg::*;

  localparam int HWORDS = BEAT_BITS / HWORD_BITS;

  logic [BEAT_BITS-1:0] inst_data;
  logic [PTAG_BITS-1:0] ptag;
  logic                 wfd;
  logic                 wfd1_vld;
  logic                 wfd4_vld;

  // ======================================================================
  // Beat data
  // ======================================================================
  // Lowest bus halfword ends up in the top slot
  always_comb
  begin
    for (int i = 0; i < HWORDS; i++)
    begin
      inst_data[i*HWORD_BITS +: HWORD_BITS] =
        beat.rdata[(HWORDS-1-i)*HWORD_BITS +: HWORD_BITS];
    end
  end

  assign ptag = PTAG_BITS'(ppc[PC_W-1:TAG_LSB]);

  // ======================================================================
  // Per-beat decode
  // ======================================================================
  assign wfd      = is_wfd(state);
  assign wfd1_vld = (state == WFD1) && beat.data_vld;
  assign wfd4_vld = (state == WFD4) && beat.data_vld;

  // Single-beat fetches bypass the cache
  assign icache_out.wr        = wfd && beat.data_vld && tsize;
  assign icache_out.first     = wfd1_vld && tsize;
  assign icache_out.last      = wfd4_vld;
  assign icache_out.index     = PC_BITS'(vpc);
  assign icache_out.ptag      = ptag;
  assign icache_out.inst_data = inst_data;

  assign ifdp_out.refill_on = refill_on;
  assign ifdp_out.inst_data = inst_data;
  assign ifdp_out.tag_valid = wfd && beat.data_vld;
  assign ifdp_out.ptag      = ptag;
  assign ifdp_out.acc_err   = wfd && beat.trans_err;

  // Refetch after the last good beat or on any error in a WFD state
  assign reissue = (wfd1_vld && !tsize) || wfd4_vld || (wfd && beat.trans_err);

endmodule

`default_nettype wire

//--- design/refill_fsm.sv
// Refill state machine with status levels and beat address increment strobe
`default_nettype none

module refill_fsm (
  input  logic                          l1_refill_clk,
  input  logic                          cpurst_b,
  input  logic                          miss_valid,
  input  logic                          inv_on,
  input  logic                          inv_busy,
  input  logic                          chgflw,
  input  refill_bus_pkg::bus_beat_t     beat,
  input  logic                          tsize,
  output refill_cfg_pkg::refill_state_e state,
  output logic                          inc,
  output logic                          busy,
  output logic                          refill_on,
  output logic                          bus_req,
  output logic                          bus_refill_on,
  output logic                          trans_cmplt,
  output logic                          miss_pre
);

  import refill_cfg_pkg::*;

  refill_state_e next_state;
  logic          start;
  logic          beat_done;

  // New refill only when no invalidate is running
  assign start     = miss_valid && !inv_on;
  // An error beat still counts as a beat on the bus
  assign beat_done = beat.data_vld || beat.trans_err;

  // ======================================================================
  // State register
  // ======================================================================
  always_ff @(posedge l1_refill_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= next_state;
    end
  end

  // ======================================================================
  // Next state
  // ======================================================================
  always_comb
  begin
    next_state = state;
    unique case (state)
      IDLE:
      begin
        if (start)
          next_state = REQ;
      end
      REQ:
      begin
        // Cancel before grant, the bus drops the request
        if (chgflw && !beat.grnt)
          next_state = IDLE;
        else if (beat.grnt)
          next_state = chgflw ? INV_WFD1 : WFD1;
      end
      WFD1:
      begin
        if (beat.data_vld)
          next_state = tsize ? WFD2 : IDLE;
        else if (beat.trans_err)
          next_state = tsize ? INV_WFD2 : IDLE;
        else if (chgflw)
          next_state = INV_WFD1;
      end
      WFD2:
      begin
        if (beat.data_vld)
          next_state = WFD3;
        else if (beat.trans_err)
          next_state = INV_WFD3;
      end
      WFD3:
      begin
        if (beat.data_vld)
          next_state = WFD4;
        else if (beat.trans_err)
          next_state = INV_WFD4;
      end
      WFD4:
      begin
        if (beat_done)
          next_state = IDLE;
      end
      // Drain path, beats are taken but not used
      INV_WFD1:
      begin
        if (beat_done)
          next_state = tsize ? INV_WFD2 : IDLE;
      end
      INV_WFD2:
      begin
        if (beat_done)
          next_state = INV_WFD3;
      end
      INV_WFD3:
      begin
        if (beat_done)
          next_state = INV_WFD4;
      end
      INV_WFD4:
      begin
        if (beat_done)
          next_state = IDLE;
      end
      default:
      begin
        next_state = IDLE;
      end
    endcase
  end

  // ======================================================================
  // Status and strobes
  // ======================================================================
  // Step the line address after beats 1 to 3 of a full line
  assign inc = beat_done && !inv_busy &&
               ((state == WFD1 && tsize) || state == WFD2 || state == WFD3);

  assign busy          = (state != IDLE);
  assign refill_on     = (state == REQ) || is_wfd(state);
  assign bus_req       = (state == REQ);
  assign bus_refill_on = (state == REQ) && !chgflw;
  assign trans_cmplt   = beat_done;
  // Miss counter event on the first returned beat
  assign miss_pre      = (state == WFD1) && beat_done;

endmodule

`default_nettype wire

//--- sim/tb_l1_refill_checks.svh
// Error and test counters, mismatch report and concurrent checks on the refill outputs

  int err_cnt   = 0;
  int test_pass = 0;
  int test_fail = 0;

  task automatic report_value(input string name, input logic [127:0] exp_v,
                              input logic [127:0] got_v);
    err_cnt++;
    $display("ERROR t=%0t %s expected %0h got %0h", $time, name, exp_v, got_v);
  endtask

  // ======================================================================
  // Status levels
  // ======================================================================
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    bus_out.req == exp_req)
    else report_value("bus_out.req", $sampled(exp_req), $sampled(bus_out.req));
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    ipctrl_busy == exp_busy)
    else report_value("ipctrl_busy", $sampled(exp_busy), $sampled(ipctrl_busy));
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    ifctrl_idle == !exp_busy)
    else report_value("ifctrl_idle", $sampled(!exp_busy), $sampled(ifctrl_idle));
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    exp_req |-> {bus_out.vpc, bus_out.ppc} == {m_vpc, 1'b0, m_ppc, 1'b0})
    else report_value("bus_out.vpc/ppc", $sampled({m_vpc, 1'b0, m_ppc, 1'b0}),
                      $sampled({bus_out.vpc, bus_out.ppc}));
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    exp_req |-> bus_out.attr == m_attr)
    else report_value("bus_out.attr", $sampled(m_attr), $sampled(bus_out.attr));
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    bus_out.refill_on == (exp_req && !chgflw))
    else report_value("bus_out.refill_on", $sampled(exp_req && !chgflw),
                      $sampled(bus_out.refill_on));
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    ifctrl_refill_on == exp_refill_on)
    else report_value("ifctrl_refill_on", $sampled(exp_refill_on),
                      $sampled(ifctrl_refill_on));
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    trans_cmplt == (beat.data_vld || beat.trans_err))
    else report_value("trans_cmplt", $sampled(beat.data_vld || beat.trans_err),
                      $sampled(trans_cmplt));
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    icache_miss_pre == exp_miss_pre)
    else report_value("icache_miss_pre", $sampled(exp_miss_pre),
                      $sampled(icache_miss_pre));

  // Request drops right after a cancel
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    bus_out.req && chgflw && !beat.grnt |=> !bus_out.req)
    else report_value("bus_out.req", 1'b0, $sampled(bus_out.req));
  // Single beat refill is over after one beat
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    exp_live && !m_attr.tsize && beat.data_vld |=> ifctrl_idle)
    else report_value("ifctrl_idle", 1'b1, $sampled(ifctrl_idle));

  // ======================================================================
  // Per-beat outputs
  // ======================================================================
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    icache_out.wr == exp_wr)
    else report_value("icache_out.wr", $sampled(exp_wr), $sampled(icache_out.wr));
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    icache_out.first == exp_first)
    else report_value("icache_out.first", $sampled(exp_first), $sampled(icache_out.first));
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    icache_out.last == exp_last)
    else report_value("icache_out.last", $sampled(exp_last), $sampled(icache_out.last));
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    ifctrl_reissue == exp_reissue)
    else report_value("ifctrl_reissue", $sampled(exp_reissue), $sampled(ifctrl_reissue));
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    ifdp_out.acc_err == exp_acc_err)
    else report_value("ifdp_out.acc_err", $sampled(exp_acc_err), $sampled(ifdp_out.acc_err));
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    exp_wr |-> icache_out.index == exp_index)
    else report_value("icache_out.index", $sampled(exp_index), $sampled(icache_out.index));
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    exp_wr |-> icache_out.inst_data == exp_data)
    else report_value("icache_out.inst_data", $sampled(exp_data),
                      $sampled(icache_out.inst_data));
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    exp_tag_vld |-> icache_out.ptag == m_ppc[38:11])
    else report_value("icache_out.ptag", $sampled(m_ppc[38:11]),
                      $sampled(icache_out.ptag));

  // Fetch stage bypass
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    ifdp_out.refill_on == exp_refill_on)
    else report_value("ifdp_out.refill_on", $sampled(exp_refill_on),
                      $sampled(ifdp_out.refill_on));
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    ifdp_out.tag_valid == exp_tag_vld)
    else report_value("ifdp_out.tag_valid", $sampled(exp_tag_vld),
                      $sampled(ifdp_out.tag_valid));
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    exp_tag_vld |-> ifdp_out.inst_data == exp_data)
    else report_value("ifdp_out.inst_data", $sampled(exp_data),
                      $sampled(ifdp_out.inst_data));
  assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    exp_tag_vld |-> ifdp_out.ptag == m_ppc[38:11])
    else report_value("ifdp_out.ptag", $sampled(m_ppc[38:11]),
                      $sampled(ifdp_out.ptag));

//--- sim/tb_l1_refill.sv
// Testbench top with clock, reset, reference model, bus model, watchdog and result line
`default_nettype none

module tb_l1_refill;

  import refill_cfg_pkg::*;
  import refill_bus_pkg::*;

  localparam int NUM_TESTS = 8;
  localparam int PERIOD    = 4;

  localparam logic [1:0] PH_IDLE = 2'd0;
  localparam logic [1:0] PH_REQ  = 2'd1;
  localparam logic [1:0] PH_DATA = 2'd2;

  logic         l1_refill_clk;
  logic         cpurst_b;
  miss_req_t    miss;
  logic         inv_on;
  logic         inv_busy;
  logic         chgflw;
  bus_beat_t    beat;
  bus_req_t     bus_out;
  icache_wr_t   icache_out;
  ifdp_data_t   ifdp_out;
  logic         ipctrl_busy;
  logic         ifctrl_idle;
  logic         ifctrl_refill_on;
  logic         ifctrl_reissue;
  logic         trans_cmplt;
  logic         icache_miss_pre;
  logic [31:0]  rng;

  // Reference model state of phase, beat count and drain flag
  logic [1:0]   m_phase;
  logic         m_drain;
  logic [1:0]   m_nb;
  logic [38:0]  m_vpc;
  logic [38:0]  m_ppc;
  refill_attr_t m_attr;

  logic         exp_live;
  logic         exp_req;
  logic         exp_busy;
  logic         exp_refill_on;
  logic         exp_tag_vld;
  logic         exp_miss_pre;
  logic         exp_wr;
  logic         exp_first;
  logic         exp_last;
  logic         exp_reissue;
  logic         exp_acc_err;
  logic [38:0]  exp_index;
  logic [127:0] exp_data;

  l1_refill_top #(.PC_W(39)) DUT (.*);

  always #(PERIOD/2) l1_refill_clk = ~l1_refill_clk;

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // First bus halfword goes to the top of the word
  function automatic logic [127:0] swap_hwords(input logic [127:0] d);
    logic [127:0] r;
    for (int j = 0; j < 8; j++)
      r[127-16*j -: 16] = d[16*j +: 16];
    return r;
  endfunction

  // ======================================================================
  // Reference model
  // ======================================================================
  always @(posedge l1_refill_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      m_phase <= PH_IDLE;
      m_drain <= 1'b0;
      m_nb    <= 2'd0;
    end
    else
    begin
      if (miss.valid)
      begin
        m_vpc  <= miss.vpc;
        m_ppc  <= miss.ppc;
        m_attr <= miss.attr;
      end
      case (m_phase)
        PH_IDLE:
        begin
          if (miss.valid && !inv_on)
          begin
            m_phase <= PH_REQ;
            m_drain <= 1'b0;
            m_nb    <= 2'd0;
          end
        end
        PH_REQ:
        begin
          if (beat.grnt)
          begin
            m_phase <= PH_DATA;
            m_drain <= chgflw;
          end
          else if (chgflw)
            m_phase <= PH_IDLE;
        end
        default:
        begin
          if (beat.data_vld || beat.trans_err)
          begin
            if (m_nb == 2'd3 || !m_attr.tsize)
              m_phase <= PH_IDLE;
            m_nb <= m_nb + 2'd1;
            if (beat.trans_err)
              m_drain <= 1'b1;
          end
          else if (chgflw && m_nb == 2'd0)
            m_drain <= 1'b1;
        end
      endcase
    end
  end

  assign exp_live      = (m_phase == PH_DATA) && !m_drain;
  assign exp_req       = (m_phase == PH_REQ);
  assign exp_busy      = (m_phase != PH_IDLE);
  assign exp_refill_on = exp_req || exp_live;
  assign exp_tag_vld   = exp_live && beat.data_vld;
  assign exp_miss_pre  = exp_live && (m_nb == 2'd0) && (beat.data_vld || beat.trans_err);
  assign exp_wr        = exp_live && beat.data_vld && m_attr.tsize;
  assign exp_first     = exp_wr && (m_nb == 2'd0);
  assign exp_last      = exp_live && beat.data_vld && (m_nb == 2'd3);
  assign exp_acc_err   = exp_live && beat.trans_err;
  assign exp_reissue   = exp_acc_err ||
                         (exp_live && beat.data_vld && (m_nb == 2'd3 || !m_attr.tsize));
  assign exp_index     = (m_nb == 2'd0) ? m_vpc : {m_vpc[38:5], m_vpc[4:3] + m_nb, 3'b000};
  assign exp_data      = swap_hwords(beat.rdata);

  `include "tb_l1_refill_checks.svh"

  // ======================================================================
  // Stimulus and bus model
  // ======================================================================
  task automatic wait_idle();
    int waited;
    waited = 0;
    while (!ifctrl_idle)
    begin
      @(posedge l1_refill_clk);
      waited++;
      if (waited > 24)
      begin
        $display("Refill did not return to idle in time");
        err_cnt++;
        return;
      end
    end
  endtask

  task automatic run_refill(input logic full, input int err_beat, input logic cancel,
                            input logic flush);
    logic [63:0]  r;
    logic [63:0]  p;
    refill_attr_t a;
    r = {next_rand(), next_rand()};
    p = {next_rand(), next_rand()};
    a = refill_attr_t'(r[5:0]);
    a.tsize = full;
    @(posedge l1_refill_clk);
    miss.valid <= 1'b1;
    miss.vpc   <= r[38:0];
    miss.ppc   <= p[38:0];
    miss.attr  <= a;
    @(posedge l1_refill_clk);
    miss.valid <= 1'b0;
    repeat (8)
    begin
      if (!bus_out.req)
        @(posedge l1_refill_clk);
    end
    if (!bus_out.req)
    begin
      $display("No bus request was raised after a miss");
      err_cnt++;
      return;
    end
    repeat (next_rand() % 4) @(posedge l1_refill_clk);
    if (cancel)
      chgflw <= 1'b1;
    else
    begin
      beat.grnt <= 1'b1;
      chgflw    <= flush;
      for (int i = 0; i < (full ? 4 : 1); i++)
      begin
        @(posedge l1_refill_clk);
        beat.grnt      <= 1'b0;
        chgflw         <= 1'b0;
        beat.data_vld  <= 1'b0;
        beat.trans_err <= 1'b0;
        repeat (next_rand() % 4) @(posedge l1_refill_clk);
        r = {next_rand(), next_rand()};
        beat.rdata     <= {r, next_rand(), next_rand()};
        beat.data_vld  <= (i != err_beat);
        beat.trans_err <= (i == err_beat);
      end
    end
    @(posedge l1_refill_clk);
    chgflw         <= 1'b0;
    beat.data_vld  <= 1'b0;
    beat.trans_err <= 1'b0;
    wait_idle();
  endtask

  task automatic close_test(input string name, input int errs_before);
    repeat (2) @(posedge l1_refill_clk);
    if (err_cnt == errs_before)
    begin
      test_pass++;
      $display("test %-22s ok", name);
    end
    else
    begin
      test_fail++;
      $display("test %-22s failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  task automatic run_test(input string name, input logic full, input int err_beat,
                          input logic cancel, input logic flush);
    int mark;
    mark = err_cnt;
    run_refill(full, err_beat, cancel, flush);
    close_test(name, mark);
  endtask

  initial
  begin
    int mark;
    rng           = 32'hd697;
    l1_refill_clk = 1'b0;
    cpurst_b      = 1'b0;
    miss          = '0;
    inv_on        = 1'b0;
    inv_busy      = 1'b0;
    chgflw        = 1'b0;
    beat          = '0;
    repeat (16) @(posedge l1_refill_clk);
    cpurst_b <= 1'b1;
    mark = err_cnt;
    repeat (4) @(posedge l1_refill_clk);
    close_test("reset defaults", mark);
    run_test("full line", 1'b1, -1, 1'b0, 1'b0);
    run_test("full line again", 1'b1, -1, 1'b0, 1'b0);
    run_test("single beat", 1'b0, -1, 1'b0, 1'b0);
    run_test("cancel before grant", 1'b1, -1, 1'b1, 1'b0);
    run_test("flush at grant", 1'b1, -1, 1'b0, 1'b1);
    run_test("error on second beat", 1'b1, 1, 1'b0, 1'b0);
    // Miss during an invalidate must not start a refill
    mark = err_cnt;
    @(posedge l1_refill_clk);
    miss.valid <= 1'b1;
    inv_on     <= 1'b1;
    @(posedge l1_refill_clk);
    miss.valid <= 1'b0;
    inv_on     <= 1'b0;
    repeat (4) @(posedge l1_refill_clk);
    close_test("miss blocked by inv_on", mark);
    $display("tests passed %0d, tests failed %0d, check errors %0d",
             test_pass, test_fail, err_cnt);
    if (test_fail == 0 && err_cnt == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  initial
  begin
    repeat (NUM_TESTS * 200) @(posedge l1_refill_clk);
    $display("Watchdog expired before all tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
